// File: hw/lsu_pkg.sv
package lsu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  byte_en_t;  // One enable per byte lane

  // Access size and extension, RISC-V funct3 codes
  typedef enum logic [2:0] {
    FUNC_B  = 3'b000,
    FUNC_H  = 3'b001,
    FUNC_W  = 3'b010,
    FUNC_BU = 3'b100,
    FUNC_HU = 3'b101
  } lsu_func_e;

  // APB request, func is a sideband field from the master
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     paddr;
    word_t     pwdata;
    lsu_func_e func;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // Decoded MMIO access, valid for one cycle
  typedef struct packed {
    logic       rd;
    logic       wr;
    logic [7:0] offset;  // Relative to 0x8000_0000
    word_t      wdata;
  } mmio_req_t;

  localparam logic [7:0] MMIO_UART_CTRL = 8'h00;  // Bit 0 tx ready, bit 1 rx valid
  localparam logic [7:0] MMIO_UART_RX   = 8'h04;  // Read takes the byte
  localparam logic [7:0] MMIO_UART_TX   = 8'h08;  // Write sends the low byte
  localparam logic [7:0] MMIO_CYCLE_CNT = 8'h10;
  localparam logic [7:0] MMIO_CNT_RST   = 8'h18;  // Any write clears the counter

endpackage

// File: hw/mem_store_align.sv
`timescale 1ns/100ps

module mem_store_align (
  input  lsu_pkg::word_t    wdata,
  input  lsu_pkg::lsu_func_e func,
  input  logic [1:0]        byte_offset,
  output lsu_pkg::word_t    lane_data,
  output lsu_pkg::byte_en_t byte_en
);
  import lsu_pkg::*;

  int exp_ones;

  // Replicate the store data so every lane carries it
  always_comb begin
    case (func)
      FUNC_B, FUNC_BU: begin
        lane_data = {4{wdata[7:0]}};
        byte_en   = 4'b0001 << byte_offset;
      end
      FUNC_H, FUNC_HU: begin
        lane_data = {2{wdata[15:0]}};
        byte_en   = byte_offset[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
      end
      FUNC_W: begin
        lane_data = wdata;
        byte_en   = 4'b1111;
      end
      default: begin
        lane_data = wdata;
        byte_en   = 4'b0000;  // Unknown size writes nothing
      end
    endcase
  end

  // Enabled lane count per access size
  always_comb begin
    case (func)
      FUNC_B, FUNC_BU: exp_ones = 1;
      FUNC_H, FUNC_HU: exp_ones = 2;
      FUNC_W:          exp_ones = 4;
      default:         exp_ones = 0;
    endcase
    assert #0 ($countones(byte_en) == exp_ones)
      else $error("store enables %b do not match access size %0d", byte_en, exp_ones);
  end

endmodule

// File: hw/mem_load_extract.sv
`timescale 1ns/100ps

module mem_load_extract (
  input  lsu_pkg::word_t     rdata,
  input  lsu_pkg::lsu_func_e func,
  input  logic [1:0]         byte_offset,
  output lsu_pkg::word_t     data
);
  import lsu_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // Addressed lanes moved down to bit 0
  assign sel_byte = rdata[{byte_offset, 3'b000} +: 8];
  assign sel_half = byte_offset[1] ? rdata[31:16] : rdata[15:0];  // Odd halfwords never get here

  always_comb begin
    case (func)
      FUNC_B: begin
        data = {{24{sel_byte[7]}}, sel_byte};
      end
      FUNC_BU: begin
        data = {24'b0, sel_byte};
      end
      FUNC_H: begin
        data = {{16{sel_half[15]}}, sel_half};
      end
      FUNC_HU: begin
        data = {16'b0, sel_half};
      end
      FUNC_W: begin
        data = rdata;
      end
      default: begin
        data = rdata;
      end
    endcase
  end

endmodule

// File: hw/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
  parameter int DMEM_AWIDTH = 14
) (
  input  logic                   clk,
  input  logic [DMEM_AWIDTH-1:0] addr,
  input  lsu_pkg::word_t         wdata,
  input  lsu_pkg::byte_en_t      byte_en,
  output lsu_pkg::word_t         rdata
);
  import lsu_pkg::*;

  localparam int DEPTH = 2 ** DMEM_AWIDTH;

  word_t mem [DEPTH];

  // Read first, so a write cycle returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
    for (int i = 0; i < 4; i++) begin
      if (byte_en[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

endmodule

// File: hw/mmio_regs.sv
`timescale 1ns/100ps

module mmio_regs (
  input  logic               clk,
  input  logic               reset,
  input  lsu_pkg::mmio_req_t mmio_req,
  output lsu_pkg::word_t     rdata,
  output logic [7:0]         tx_data,
  output logic               tx_valid,
  input  logic               tx_ready,
  input  logic [7:0]         rx_data,
  input  logic               rx_valid,
  output logic               rx_ready
);
  import lsu_pkg::*;

  word_t cycle_cnt;
  word_t rd_mux;
  logic  cnt_clear;

  assign tx_data   = mmio_req.wdata[7:0];
  // A tx write while the transmitter is busy is dropped
  assign tx_valid  = mmio_req.wr && (mmio_req.offset == MMIO_UART_TX) && tx_ready;
  assign rx_ready  = mmio_req.rd && (mmio_req.offset == MMIO_UART_RX);  // Reading RX takes the byte
  assign cnt_clear = mmio_req.wr && (mmio_req.offset == MMIO_CNT_RST);

  always_ff @(posedge clk) begin
    if (reset || cnt_clear) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 32'd1;
    end
  end

  always_comb begin
    case (mmio_req.offset)
      MMIO_UART_CTRL: rd_mux = {30'b0, rx_valid, tx_ready};
      MMIO_UART_RX:   rd_mux = {24'b0, rx_data};
      MMIO_CYCLE_CNT: rd_mux = cycle_cnt;
      default:        rd_mux = '0;  // Write-only and unused offsets
    endcase
  end

  // One cycle read latency like the data memory
  always_ff @(posedge clk) begin
    rdata <= mmio_req.rd ? rd_mux : '0;
  end

  // An accepted byte must make the transmitter busy on the next cycle
  assert property (@(posedge clk) disable iff (reset)
    tx_valid |=> !tx_ready)
    else $error("transmitter still ready after taking a byte");

endmodule

// File: hw/uart_transmitter.sv
`timescale 1ns/100ps

module uart_transmitter #(
  parameter int CLOCK_FREQ = 50_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] data_in,
  input  logic       data_in_valid,
  output logic       data_in_ready,
  output logic       serial_out
);

  localparam int SYMBOL_EDGE_TIME = CLOCK_FREQ / BAUD_RATE;  // Clocks per bit
  localparam int CNT_W            = $clog2(SYMBOL_EDGE_TIME);

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic [9:0]       tx_shift;  // Stop, data, start
  logic             busy;
  logic             symbol_edge;

  assign symbol_edge   = (clk_cnt == CNT_W'(SYMBOL_EDGE_TIME - 1));
  assign data_in_ready = ~busy;
  assign serial_out    = tx_shift[0];  // Line idles high

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      tx_shift <= '1;
    end else if (!busy) begin
      clk_cnt <= '0;
      bit_cnt <= '0;
      if (data_in_valid) begin
        busy     <= 1'b1;
        tx_shift <= {1'b1, data_in, 1'b0};
      end
    end else if (symbol_edge) begin
      clk_cnt  <= '0;
      bit_cnt  <= bit_cnt + 4'd1;
      tx_shift <= {1'b1, tx_shift[9:1]};  // LSB first, refill with idle
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;  // End of stop bit
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

// File: hw/uart_receiver.sv
`timescale 1ns/100ps

module uart_receiver #(
  parameter int CLOCK_FREQ = 50_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       serial_in,
  output logic [7:0] data_out,
  output logic       data_out_valid,
  input  logic       data_out_ready
);

  localparam int SYMBOL_EDGE_TIME = CLOCK_FREQ / BAUD_RATE;
  localparam int SAMPLE_TIME      = SYMBOL_EDGE_TIME / 2;  // Middle of the bit
  localparam int CNT_W            = $clog2(SYMBOL_EDGE_TIME);

  logic [1:0]       rx_sync;
  logic             rx_bit;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;  // 0 start, 1 to 8 data, 9 stop
  logic [7:0]       rx_shift;
  logic             busy;
  logic             has_byte;
  logic             symbol_edge;
  logic             sample_now;
  logic             byte_done;

  assign rx_bit         = rx_sync[1];
  assign symbol_edge    = (clk_cnt == CNT_W'(SYMBOL_EDGE_TIME - 1));
  assign sample_now     = busy && (clk_cnt == CNT_W'(SAMPLE_TIME));
  assign byte_done      = sample_now && (bit_cnt == 4'd9) && rx_bit;  // Needs a high stop bit
  assign data_out_valid = has_byte;

  // Two flop synchronizer on the async line
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], serial_in};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      clk_cnt <= '0;
      bit_cnt <= '0;
      busy    <= ~rx_bit;  // Falling edge starts a frame
    end else begin
      clk_cnt <= symbol_edge ? '0 : clk_cnt + 1'b1;
      if (symbol_edge) begin
        bit_cnt <= bit_cnt + 4'd1;
      end
      if (sample_now && (bit_cnt == 4'd0) && rx_bit) begin
        busy <= 1'b0;  // Glitch, not a start bit
      end
      if (sample_now && (bit_cnt == 4'd9)) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_now && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8)) begin
      rx_shift <= {rx_bit, rx_shift[7:1]};  // LSB arrives first
    end
  end

  // Held until taken; a byte finishing while one is held is lost
  always_ff @(posedge clk) begin
    if (reset) begin
      has_byte <= 1'b0;
    end else if (byte_done && !has_byte) begin
      has_byte <= 1'b1;
    end else if (has_byte && data_out_ready) begin
      has_byte <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (byte_done && !has_byte) begin
      data_out <= rx_shift;
    end
  end

endmodule

// File: hw/lsu_mmio_top.sv
`timescale 1ns/100ps

module lsu_mmio_top #(
  parameter int DMEM_AWIDTH = 14,
  parameter int CLOCK_FREQ  = 50_000_000,
  parameter int BAUD_RATE   = 115_200
) (
  input  logic              clk,
  input  logic              reset,
  input  lsu_pkg::apb_req_t apb_req,
  output lsu_pkg::apb_rsp_t apb_rsp,
  input  logic              serial_rx,
  output logic              serial_tx
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESPOND
  } apb_state_e;

  apb_state_e state;
  logic       dmem_hit, mmio_hit, misaligned, access_err, do_access;
  logic       err_q, mmio_sel_q;
  lsu_func_e  func_q;
  logic [1:0] offset_q;
  word_t      lane_data, ram_rdata, mmio_rdata, load_word, load_data;
  byte_en_t   align_be, ram_be;
  mmio_req_t  mmio_req;
  logic [7:0] tx_data, rx_data;
  logic       tx_valid, tx_ready, rx_valid, rx_ready;

  assign dmem_hit   = (apb_req.paddr[31:28] & 4'b1101) == 4'b0001;  // 0x1 and 0x3 alias
  assign mmio_hit   = apb_req.paddr[31];
  assign access_err = misaligned || !(dmem_hit || mmio_hit);
  assign do_access  = (state == ST_ACCESS) && apb_req.psel && apb_req.penable;

  always_comb begin
    case (apb_req.func)
      FUNC_H, FUNC_HU: misaligned = apb_req.paddr[0];
      FUNC_W:          misaligned = |apb_req.paddr[1:0];
      default:         misaligned = 1'b0;
    endcase
  end

  // Setup, first access, then the response cycle with pready
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:    if (apb_req.psel && !apb_req.penable) state <= ST_ACCESS;
        ST_ACCESS:  if (do_access) state <= ST_RESPOND;
                    else if (!apb_req.psel) state <= ST_IDLE;
        ST_RESPOND: state <= ST_IDLE;
        default:    state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      err_q <= 1'b0;
    end else if (do_access) begin
      err_q <= access_err;
    end
  end

  // Read path select and extract controls
  always_ff @(posedge clk) begin
    if (do_access) begin
      mmio_sel_q <= mmio_hit;
      func_q     <= apb_req.func;
      offset_q   <= apb_req.paddr[1:0];
    end
  end

  assign ram_be    = (do_access && apb_req.pwrite && dmem_hit && !access_err) ? align_be : '0;
  assign load_word = mmio_sel_q ? mmio_rdata : ram_rdata;

  always_comb begin
    mmio_req.rd     = do_access && !apb_req.pwrite && mmio_hit && !access_err;
    mmio_req.wr     = do_access && apb_req.pwrite && mmio_hit && !access_err;
    mmio_req.offset = apb_req.paddr[7:0];
    mmio_req.wdata  = lane_data;
  end

  always_comb begin
    apb_rsp.pready  = (state == ST_RESPOND);
    apb_rsp.pslverr = (state == ST_RESPOND) && err_q;
    apb_rsp.prdata  = err_q ? '0 : load_data;  // Failed transfers read zero
  end

  mem_store_align u_store_align (
    .wdata      (apb_req.pwdata),
    .func       (apb_req.func),
    .byte_offset(apb_req.paddr[1:0]),
    .lane_data  (lane_data),
    .byte_en    (align_be)
  );

  data_ram #(
    .DMEM_AWIDTH(DMEM_AWIDTH)
  ) u_dmem (
    .clk    (clk),
    .addr   (apb_req.paddr[DMEM_AWIDTH+1:2]),
    .wdata  (lane_data),
    .byte_en(ram_be),
    .rdata  (ram_rdata)
  );

  mmio_regs u_mmio (
    .clk     (clk),
    .reset   (reset),
    .mmio_req(mmio_req),
    .rdata   (mmio_rdata),
    .tx_data (tx_data),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .rx_data (rx_data),
    .rx_valid(rx_valid),
    .rx_ready(rx_ready)
  );

  mem_load_extract u_load_extract (
    .rdata      (load_word),
    .func       (func_q),
    .byte_offset(offset_q),
    .data       (load_data)
  );

  uart_transmitter #(
    .CLOCK_FREQ(CLOCK_FREQ),
    .BAUD_RATE (BAUD_RATE)
  ) u_uart_tx (
    .clk          (clk),
    .reset        (reset),
    .data_in      (tx_data),
    .data_in_valid(tx_valid),
    .data_in_ready(tx_ready),
    .serial_out   (serial_tx)
  );

  uart_receiver #(
    .CLOCK_FREQ(CLOCK_FREQ),
    .BAUD_RATE (BAUD_RATE)
  ) u_uart_rx (
    .clk           (clk),
    .reset         (reset),
    .serial_in     (serial_rx),
    .data_out      (rx_data),
    .data_out_valid(rx_valid),
    .data_out_ready(rx_ready)
  );

  // Access phase only inside a selected transfer that began with setup
  assert property (@(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
    else $error("penable without psel or without a setup cycle");

endmodule

// File: verif/tb_lsu_mmio.sv
`timescale 1ns/100ps

module tb_lsu_mmio;
  import lsu_pkg::*;

  localparam int    APB_WAIT_MAX = 8;    // Cycles from penable to pready
  localparam int    POLL_MAX     = 200;  // Status reads before giving up
  localparam word_t DMEM_BASE    = 32'h1000_0000;
  localparam word_t MMIO_BASE    = 32'h8000_0000;

  logic        clk;
  logic        reset;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        serial_line;  // tx looped back into rx
  logic [31:0] lfsr_state;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;

  lsu_mmio_top #(
    .DMEM_AWIDTH(14),
    .CLOCK_FREQ (1_000_000),
    .BAUD_RATE  (100_000)
  ) u_dut (
    .clk      (clk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .serial_rx(serial_line),
    .serial_tx(serial_line)
  );

  always #10 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t rand_bits(input int nbits);
    word_t v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s pslverr %b, expected %b", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_wait_states(input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t ns: pready after %0d wait states, expected %0d",
               $time, got, exp);
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    if (test_errs == 0) begin
      $display("[%0t ns] %s: ok", $time, name);
      pass_cnt++;
    end else begin
      $display("[%0t ns] %s: %0d errors", $time, name, test_errs);
      fail_cnt++;
    end
  endtask

  // Setup cycle, then access until pready
  task automatic apb_transfer(input logic write, input word_t addr, input word_t wdata,
                              input lsu_func_e func, output word_t rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.func    = func;
    @(negedge clk);
    apb_req.penable = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!apb_rsp.pready && waited < APB_WAIT_MAX);
    if (!apb_rsp.pready) begin
      abort_run("APB transfer never saw pready");
    end else begin
      check_wait_states(waited, 1);  // Exactly one wait state per transfer
      rdata           = apb_rsp.prdata;
      err             = apb_rsp.pslverr;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
    end
  endtask

  task automatic apb_write(input word_t addr, input word_t wdata, input lsu_func_e func,
                           output logic err);
    word_t unused;
    apb_transfer(1'b1, addr, wdata, func, unused, err);
  endtask

  task automatic apb_read(input word_t addr, input lsu_func_e func, output word_t rdata,
                          output logic err);
    apb_transfer(1'b0, addr, 32'h0, func, rdata, err);
  endtask

  // Reads UART status until the given bit is set
  task automatic poll_ctrl(input int bit_idx, input string what);
    word_t status;
    logic  err;
    int    polls;
    polls = 0;
    do begin
      apb_read(MMIO_BASE | {24'b0, MMIO_UART_CTRL}, FUNC_W, status, err);
      polls++;
    end while (!status[bit_idx] && polls < POLL_MAX);
    if (!status[bit_idx]) begin
      abort_run({"Gave up waiting for ", what});
    end
  endtask

  // Both directions must fail and the read returns zero
  task automatic expect_slverr(input string what, input word_t addr, input lsu_func_e func,
                               input word_t wdata);
    word_t rdata;
    logic  err;
    apb_write(addr, wdata, func, err);
    check_err({what, " store"}, err, 1'b1);
    apb_read(addr, func, rdata, err);
    check_err({what, " load"}, err, 1'b1);
    check_word({what, " load data"}, rdata, 32'h0);
  endtask

  task automatic test_word_rw();
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  err;
    test_errs = 0;
    for (int i = 0; i < 6; i++) begin
      addr  = DMEM_BASE | (rand_bits(12) << 2);
      wdata = rand_bits(32);
      apb_write(addr, wdata, FUNC_W, err);
      check_err("word store", err, 1'b0);
      apb_read(addr, FUNC_W, rdata, err);
      check_err("word load", err, 1'b0);
      check_word("word load", rdata, wdata);
      apb_read(addr | 32'h2000_0000, FUNC_W, rdata, err);  // 0x3 alias of 0x1
      check_word("alias load", rdata, wdata);
    end
    report_test("word store and load");
  endtask

  task automatic test_subword_store();
    word_t base;
    word_t init;
    word_t wdata;
    word_t exp;
    word_t rdata;
    logic  err;
    test_errs = 0;
    base = DMEM_BASE | 32'h0000_8000;
    for (int k = 0; k < 4; k++) begin
      init  = rand_bits(32);
      wdata = rand_bits(32);  // Upper bits must be ignored
      apb_write(base, init, FUNC_W, err);
      apb_write(base + word_t'(k), wdata, FUNC_B, err);
      check_err("byte store", err, 1'b0);
      exp = init;
      exp[8*k +: 8] = wdata[7:0];
      apb_read(base, FUNC_W, rdata, err);
      check_word("word after byte store", rdata, exp);
    end
    for (int k = 0; k < 4; k += 2) begin
      init  = rand_bits(32);
      wdata = rand_bits(32);
      apb_write(base, init, FUNC_W, err);
      apb_write(base + word_t'(k), wdata, FUNC_H, err);
      check_err("halfword store", err, 1'b0);
      exp = init;
      exp[8*k +: 16] = wdata[15:0];
      apb_read(base, FUNC_W, rdata, err);
      check_word("word after halfword store", rdata, exp);
    end
    report_test("sub-word stores");
  endtask

  task automatic test_subword_load();
    word_t       addr;
    word_t       pattern;
    word_t       rdata;
    logic        err;
    logic [7:0]  b;
    logic [15:0] h;
    test_errs = 0;
    addr = DMEM_BASE | 32'h0000_8100;
    for (int n = 0; n < 2; n++) begin
      // First pass sets every lane's top bit, second clears it
      pattern = (n == 0) ? (rand_bits(32) | 32'h8080_8080) : (rand_bits(32) & 32'h7f7f_7f7f);
      apb_write(addr, pattern, FUNC_W, err);
      for (int k = 0; k < 4; k++) begin
        b = pattern[8*k +: 8];
        apb_read(addr + word_t'(k), FUNC_B, rdata, err);
        check_err("lb", err, 1'b0);
        check_word("lb", rdata, {{24{b[7]}}, b});
        apb_read(addr + word_t'(k), FUNC_BU, rdata, err);
        check_word("lbu", rdata, {24'b0, b});
        if (k % 2 == 0) begin
          h = pattern[8*k +: 16];
          apb_read(addr + word_t'(k), FUNC_H, rdata, err);
          check_err("lh", err, 1'b0);
          check_word("lh", rdata, {{16{h[15]}}, h});
          apb_read(addr + word_t'(k), FUNC_HU, rdata, err);
          check_word("lhu", rdata, {16'b0, h});
        end
      end
    end
    report_test("sub-word loads");
  endtask

  task automatic test_access_errors();
    word_t addr;
    word_t keep;
    word_t rdata;
    logic  err;
    test_errs = 0;
    addr = DMEM_BASE | 32'h0000_9000;
    keep = rand_bits(32);
    apb_write(addr, keep, FUNC_W, err);
    check_err("setup store", err, 1'b0);
    // All three land on the same memory word as addr
    expect_slverr("unmapped", 32'h0000_9000, FUNC_W, ~keep);
    expect_slverr("odd halfword", addr + 32'd1, FUNC_H, ~keep);
    expect_slverr("misaligned word", addr + 32'd2, FUNC_W, ~keep);
    apb_read(addr, FUNC_W, rdata, err);
    check_err("reread", err, 1'b0);
    check_word("reread", rdata, keep);
    report_test("access errors");
  endtask

  task automatic test_uart_loopback();
    word_t tx_byte;
    word_t rdata;
    logic  err;
    test_errs = 0;
    tx_byte = rand_bits(8);
    poll_ctrl(0, "tx ready");
    apb_write(MMIO_BASE | {24'b0, MMIO_UART_TX}, (rand_bits(24) << 8) | tx_byte, FUNC_W, err);
    check_err("tx write", err, 1'b0);
    poll_ctrl(1, "rx valid");
    apb_read(MMIO_BASE | {24'b0, MMIO_UART_RX}, FUNC_W, rdata, err);
    check_err("rx read", err, 1'b0);
    check_word("rx byte", rdata, tx_byte);
    apb_read(MMIO_BASE | {24'b0, MMIO_UART_CTRL}, FUNC_W, rdata, err);
    check_word("rx valid after take", {31'b0, rdata[1]}, 32'h0);
    report_test("UART loopback");
  endtask

  task automatic test_cycle_counter();
    word_t first;
    word_t second;
    word_t rdata;
    logic  err;
    test_errs = 0;
    apb_read(MMIO_BASE | {24'b0, MMIO_CYCLE_CNT}, FUNC_W, first, err);
    apb_read(MMIO_BASE | {24'b0, MMIO_CYCLE_CNT}, FUNC_W, second, err);
    check_err("counter read", err, 1'b0);
    check_word("counter step", second - first, 32'd3);  // Back-to-back reads are 3 cycles apart
    apb_write(MMIO_BASE | {24'b0, MMIO_CNT_RST}, rand_bits(32), FUNC_W, err);
    check_err("counter clear", err, 1'b0);
    apb_read(MMIO_BASE | {24'b0, MMIO_CYCLE_CNT}, FUNC_W, rdata, err);
    check_word("counter after clear", rdata, 32'd2);  // Cleared, then two idle edges
    report_test("cycle counter");
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    apb_req    = '0;
    lfsr_state = 32'hf4c926bf;
    pass_cnt   = 0;
    fail_cnt   = 0;
    test_errs  = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_word_rw();
    test_subword_store();
    test_subword_load();
    test_access_errors();
    test_uart_loopback();
    test_cycle_counter();

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
hw/lsu_pkg.sv
hw/mem_store_align.sv
hw/mem_load_extract.sv
hw/data_ram.sv
hw/mmio_regs.sv
hw/uart_transmitter.sv
hw/uart_receiver.sv
hw/lsu_mmio_top.sv
verif/tb_lsu_mmio.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lsu_mmio -f files.f -o sim_lsu_mmio

./obj_dir/sim_lsu_mmio | tee sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
fi
exit 1
